// File: include/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// data path and pc width
`define EXEC_XLEN  32

// integer register file size and its address width
`define EXEC_NREGS 32
`define EXEC_RA_W  5

`endif

// File: src/isa_pkg.sv
package isa_pkg;

  // operation class of a decoded micro-op
  typedef enum logic [2:0] {
    ALR,
    ALI,
    LUI,
    AUIPC,
    JAL,
    JALR,
    BRANCH
  } fu_op_e;

  // function within a class, NONE for the pc and upper-immediate classes
  typedef enum logic [4:0] {
    ADD, SUB, SLL, SLT, SLTU,
    XOR, SRL, SRA, OR, AND,
    ADDI, SLLI, SLTI, SLTUI, XORI,
    SRLI, SRAI, ORI, ANDI,
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    NONE
  } fu_func_e;

endpackage

// File: src/ctrl_pkg.sv
package ctrl_pkg;

  // phases of the single micro-op in flight
  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    WB
  } exec_state_e;

endpackage

// File: src/alu.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module alu (
  input  logic [`EXEC_XLEN-1:0] rs1_i,
  input  logic [`EXEC_XLEN-1:0] rs2_i,
  input  logic [`EXEC_XLEN-1:0] pc_i,
  input  logic [`EXEC_XLEN-1:0] imm_i,
  input  isa_pkg::fu_op_e       fu_op_i,
  input  isa_pkg::fu_func_e     fu_func_i,
  output logic [`EXEC_XLEN-1:0] alu_res_o,
  output logic                  jump_o
);

  localparam int SHAMT_W = $clog2(`EXEC_XLEN);

  logic [`EXEC_XLEN-1:0] src1;
  logic [`EXEC_XLEN-1:0] src2;
  logic                  adder_sub;
  logic [`EXEC_XLEN-1:0] adder_src2;
  logic [`EXEC_XLEN-1:0] adder_res;
  logic                  adder_cout;
  logic [SHAMT_W-1:0]    shamt;
  logic                  eq;
  logic                  lt;
  logic                  ltu;

  //////////////////////////////////////////////////
  // operand selection
  //////////////////////////////////////////////////
  always_comb begin
    if (fu_op_i inside {isa_pkg::AUIPC, isa_pkg::JAL, isa_pkg::JALR}) begin
      src1 = pc_i;
    end else if (fu_op_i == isa_pkg::LUI) begin
      src1 = '0;
    end else begin
      src1 = rs1_i;
    end

    if (fu_op_i inside {isa_pkg::ALR, isa_pkg::BRANCH}) begin
      src2 = rs2_i;
    end else if (fu_op_i inside {isa_pkg::JAL, isa_pkg::JALR}) begin
      // link address is pc+4
      src2 = `EXEC_XLEN'd4;
    end else begin
      src2 = imm_i;
    end
  end

  // one adder serves add, subtract and every compare
  assign adder_sub = (fu_op_i == isa_pkg::BRANCH) ||
                     (fu_func_i inside {isa_pkg::SUB, isa_pkg::SLT, isa_pkg::SLTI,
                                        isa_pkg::SLTU, isa_pkg::SLTUI});
  assign adder_src2 = src2 ^ {`EXEC_XLEN{adder_sub}};
  assign {adder_cout, adder_res} = {1'b0, src1} + {1'b0, adder_src2} +
                                   {{`EXEC_XLEN{1'b0}}, adder_sub};

  assign shamt = src2[SHAMT_W-1:0];

  // carry out of a-b set means no borrow, so a is not below b unsigned
  assign eq  = (src1 == src2);
  assign ltu = ~adder_cout;
  assign lt  = (src1[`EXEC_XLEN-1] & ~src2[`EXEC_XLEN-1]) |
               (~(src1[`EXEC_XLEN-1] ^ src2[`EXEC_XLEN-1]) & adder_res[`EXEC_XLEN-1]);

  //////////////////////////////////////////////////
  // result and branch decision
  //////////////////////////////////////////////////
  always_comb begin
    case (fu_func_i)
      isa_pkg::SLL, isa_pkg::SLLI:   alu_res_o = src1 << shamt;
      isa_pkg::SLT, isa_pkg::SLTI:   alu_res_o = {{(`EXEC_XLEN-1){1'b0}}, lt};
      isa_pkg::SLTU, isa_pkg::SLTUI: alu_res_o = {{(`EXEC_XLEN-1){1'b0}}, ltu};
      isa_pkg::XOR, isa_pkg::XORI:   alu_res_o = src1 ^ src2;
      isa_pkg::SRL, isa_pkg::SRLI:   alu_res_o = src1 >> shamt;
      isa_pkg::SRA, isa_pkg::SRAI:   alu_res_o = $signed(src1) >>> shamt;
      isa_pkg::OR, isa_pkg::ORI:     alu_res_o = src1 | src2;
      isa_pkg::AND, isa_pkg::ANDI:   alu_res_o = src1 & src2;
      default:                       alu_res_o = adder_res;
    endcase
  end

  always_comb begin
    jump_o = 1'b0;
    if (fu_op_i == isa_pkg::BRANCH) begin
      case (fu_func_i)
        isa_pkg::BEQ:  jump_o = eq;
        isa_pkg::BNE:  jump_o = ~eq;
        isa_pkg::BLT:  jump_o = lt;
        isa_pkg::BGE:  jump_o = ~lt;
        isa_pkg::BLTU: jump_o = ltu;
        isa_pkg::BGEU: jump_o = ~ltu;
        default:       jump_o = 1'b0;
      endcase
    end
  end

endmodule

// File: src/regfile.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module regfile (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [`EXEC_RA_W-1:0] ra1_i,
  input  logic [`EXEC_RA_W-1:0] ra2_i,
  output logic [`EXEC_XLEN-1:0] rd1_o,
  output logic [`EXEC_XLEN-1:0] rd2_o,
  input  logic                  we_i,
  input  logic [`EXEC_RA_W-1:0] wa_i,
  input  logic [`EXEC_XLEN-1:0] wd_i
);

  logic [`EXEC_XLEN-1:0] regs [`EXEC_NREGS];

  // x0 never takes a write, so it stays at its reset value of zero
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `EXEC_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (wa_i != '0)) begin
      regs[wa_i] <= wd_i;
    end
  end

  assign rd1_o = regs[ra1_i];
  assign rd2_o = regs[ra2_i];

endmodule

// File: src/uop_latch.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module uop_latch (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  capture_i,
  input  logic                  result_load_i,
  input  isa_pkg::fu_op_e       fu_op_i,
  input  isa_pkg::fu_func_e     fu_func_i,
  input  logic [`EXEC_RA_W-1:0] rs1_addr_i,
  input  logic [`EXEC_RA_W-1:0] rs2_addr_i,
  input  logic [`EXEC_RA_W-1:0] rd_addr_i,
  input  logic [`EXEC_XLEN-1:0] imm_i,
  input  logic [`EXEC_XLEN-1:0] alu_res_i,
  input  logic                  jump_i,
  output isa_pkg::fu_op_e       fu_op_o,
  output isa_pkg::fu_func_e     fu_func_o,
  output logic [`EXEC_RA_W-1:0] rs1_addr_o,
  output logic [`EXEC_RA_W-1:0] rs2_addr_o,
  output logic [`EXEC_RA_W-1:0] rd_addr_o,
  output logic [`EXEC_XLEN-1:0] imm_o,
  output logic [`EXEC_XLEN-1:0] result_o,
  output logic                  jump_o
);

  // class and function steer the write enable and next pc
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fu_op_o   <= isa_pkg::ALR;
      fu_func_o <= isa_pkg::NONE;
    end else if (capture_i) begin
      fu_op_o   <= fu_op_i;
      fu_func_o <= fu_func_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      rs1_addr_o <= rs1_addr_i;
      rs2_addr_o <= rs2_addr_i;
      rd_addr_o  <= rd_addr_i;
      imm_o      <= imm_i;
    end
    if (result_load_i) begin
      result_o <= alu_res_i;
      jump_o   <= jump_i;
    end
  end

endmodule

// File: src/pc_counter.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module pc_counter (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  advance_i,
  input  isa_pkg::fu_op_e       fu_op_i,
  input  logic                  jump_i,
  input  logic [`EXEC_XLEN-1:0] imm_i,
  input  logic [`EXEC_XLEN-1:0] rs1_i,
  output logic [`EXEC_XLEN-1:0] pc_o,
  output logic [`EXEC_XLEN-1:0] retire_cnt_o
);

  logic [`EXEC_XLEN-1:0] pc_next;
  logic [`EXEC_XLEN-1:0] jalr_tgt;

  assign jalr_tgt = rs1_i + imm_i;

  always_comb begin
    case (fu_op_i)
      isa_pkg::JAL:    pc_next = pc_o + imm_i;
      isa_pkg::JALR:   pc_next = {jalr_tgt[`EXEC_XLEN-1:1], 1'b0};
      isa_pkg::BRANCH: pc_next = jump_i ? (pc_o + imm_i) : (pc_o + `EXEC_XLEN'd4);
      default:         pc_next = pc_o + `EXEC_XLEN'd4;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_o         <= '0;
      retire_cnt_o <= '0;
    end else if (advance_i) begin
      pc_o         <= pc_next;
      retire_cnt_o <= retire_cnt_o + 1'b1;
    end
  end

endmodule

// File: src/exec_ctrl.sv
`timescale 1ns/1ps

module exec_ctrl (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            uop_valid_i,
  input  isa_pkg::fu_op_e fu_op_i,
  output logic            capture_o,
  output logic            result_load_o,
  output logic            wb_en_o,
  output logic            rf_we_o,
  output logic            busy_o
);

  ctrl_pkg::exec_state_e state_q;
  ctrl_pkg::exec_state_e state_d;
  logic                  opnd_wait_q;

  // first EXEC cycle lets the latched addresses settle through the register file
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= ctrl_pkg::IDLE;
      opnd_wait_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      opnd_wait_q <= capture_o;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ctrl_pkg::IDLE: if (uop_valid_i) state_d = ctrl_pkg::EXEC;
      ctrl_pkg::EXEC: if (!opnd_wait_q) state_d = ctrl_pkg::WB;
      ctrl_pkg::WB:   state_d = ctrl_pkg::IDLE;
      default:        state_d = ctrl_pkg::IDLE;
    endcase
  end

  assign capture_o     = (state_q == ctrl_pkg::IDLE) && uop_valid_i;
  assign result_load_o = (state_q == ctrl_pkg::EXEC) && !opnd_wait_q;
  assign wb_en_o       = (state_q == ctrl_pkg::WB);
  // branches retire without touching the register file
  assign rf_we_o       = wb_en_o && (fu_op_i != isa_pkg::BRANCH);
  assign busy_o        = (state_q != ctrl_pkg::IDLE);

endmodule

// File: src/exec_core.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_core (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  uop_valid_i,
  input  isa_pkg::fu_op_e       fu_op_i,
  input  isa_pkg::fu_func_e     fu_func_i,
  input  logic [`EXEC_RA_W-1:0] rs1_addr_i,
  input  logic [`EXEC_RA_W-1:0] rs2_addr_i,
  input  logic [`EXEC_RA_W-1:0] rd_addr_i,
  input  logic [`EXEC_XLEN-1:0] imm_i,
  output logic                  busy_o,
  output logic                  wb_valid_o,
  output logic [`EXEC_RA_W-1:0] wb_rd_o,
  output logic [`EXEC_XLEN-1:0] wb_data_o,
  output logic [`EXEC_XLEN-1:0] pc_o,
  output logic [`EXEC_XLEN-1:0] retire_cnt_o
);

  logic                  capture;
  logic                  result_load;
  logic                  wb_en;
  logic                  rf_we;
  isa_pkg::fu_op_e       lat_op;
  isa_pkg::fu_func_e     lat_func;
  logic [`EXEC_RA_W-1:0] lat_rs1;
  logic [`EXEC_RA_W-1:0] lat_rs2;
  logic [`EXEC_RA_W-1:0] lat_rd;
  logic [`EXEC_XLEN-1:0] lat_imm;
  logic [`EXEC_XLEN-1:0] result;
  logic                  lat_jump;
  logic [`EXEC_XLEN-1:0] rd1;
  logic [`EXEC_XLEN-1:0] rd2;
  logic [`EXEC_XLEN-1:0] alu_res;
  logic                  alu_jump;

  //////////////////////////////////////////////////
  // control and micro-op state
  //////////////////////////////////////////////////
  exec_ctrl u_ctrl (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .uop_valid_i(uop_valid_i), .fu_op_i(lat_op),
    .capture_o(capture), .result_load_o(result_load), .wb_en_o(wb_en),
    .rf_we_o(rf_we), .busy_o(busy_o)
  );

  uop_latch u_latch (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .capture_i(capture), .result_load_i(result_load),
    .fu_op_i(fu_op_i), .fu_func_i(fu_func_i), .rs1_addr_i(rs1_addr_i),
    .rs2_addr_i(rs2_addr_i), .rd_addr_i(rd_addr_i), .imm_i(imm_i),
    .alu_res_i(alu_res), .jump_i(alu_jump), .fu_op_o(lat_op), .fu_func_o(lat_func),
    .rs1_addr_o(lat_rs1), .rs2_addr_o(lat_rs2), .rd_addr_o(lat_rd), .imm_o(lat_imm),
    .result_o(result), .jump_o(lat_jump)
  );

  //////////////////////////////////////////////////
  // data path
  //////////////////////////////////////////////////
  regfile u_rf (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .ra1_i(lat_rs1), .ra2_i(lat_rs2),
    .rd1_o(rd1), .rd2_o(rd2), .we_i(rf_we), .wa_i(lat_rd), .wd_i(result)
  );

  alu u_alu (
    .rs1_i(rd1), .rs2_i(rd2), .pc_i(pc_o), .imm_i(lat_imm), .fu_op_i(lat_op),
    .fu_func_i(lat_func), .alu_res_o(alu_res), .jump_o(alu_jump)
  );

  pc_counter u_pc (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .advance_i(wb_en), .fu_op_i(lat_op),
    .jump_i(lat_jump), .imm_i(lat_imm), .rs1_i(rd1), .pc_o(pc_o),
    .retire_cnt_o(retire_cnt_o)
  );

  assign wb_valid_o = wb_en;
  assign wb_rd_o    = lat_rd;
  assign wb_data_o  = result;

endmodule

// File: bench/exec_core_sva.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_core_sva (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic                  uop_valid_i,
  input isa_pkg::fu_op_e       fu_op_i,
  input isa_pkg::fu_func_e     fu_func_i,
  input logic [`EXEC_RA_W-1:0] rs1_addr_i,
  input logic [`EXEC_RA_W-1:0] rs2_addr_i,
  input logic [`EXEC_RA_W-1:0] rd_addr_i,
  input logic [`EXEC_XLEN-1:0] imm_i,
  input logic                  busy_i,
  input logic                  wb_valid_i,
  input logic [`EXEC_RA_W-1:0] wb_rd_i,
  input logic [`EXEC_XLEN-1:0] wb_data_i,
  input logic [`EXEC_XLEN-1:0] pc_i,
  input logic [`EXEC_XLEN-1:0] retire_cnt_i
);

  logic [`EXEC_XLEN-1:0] sregs [`EXEC_NREGS];
  logic [`EXEC_XLEN-1:0] spc;
  logic [`EXEC_XLEN-1:0] scnt;
  logic [`EXEC_XLEN-1:0] exp_res;
  logic [`EXEC_XLEN-1:0] exp_pc;
  logic                  exp_wr;
  logic [`EXEC_RA_W-1:0] exp_rd;
  logic [2:0]            since_acc;
  logic                  accept;
  logic                  exp_busy;
  logic                  exp_wb;
  int                    err_cnt = 0;

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  function automatic logic [`EXEC_XLEN-1:0] model_res(
    input isa_pkg::fu_op_e op, input isa_pkg::fu_func_e fn,
    input logic [`EXEC_XLEN-1:0] a, input logic [`EXEC_XLEN-1:0] b,
    input logic [`EXEC_XLEN-1:0] imm, input logic [`EXEC_XLEN-1:0] pc);
    logic [`EXEC_XLEN-1:0] y;
    y = (op == isa_pkg::ALR) ? b : imm;
    case (op)
      isa_pkg::LUI:                return imm;
      isa_pkg::AUIPC:              return pc + imm;
      isa_pkg::JAL, isa_pkg::JALR: return pc + `EXEC_XLEN'd4;
      default: ;
    endcase
    // shift amounts come from the low five bits of the second operand
    case (fn)
      isa_pkg::SUB:                  return a - y;
      isa_pkg::SLL, isa_pkg::SLLI:   return a << y[4:0];
      isa_pkg::SLT, isa_pkg::SLTI:   return {{(`EXEC_XLEN-1){1'b0}}, $signed(a) < $signed(y)};
      isa_pkg::SLTU, isa_pkg::SLTUI: return {{(`EXEC_XLEN-1){1'b0}}, a < y};
      isa_pkg::XOR, isa_pkg::XORI:   return a ^ y;
      isa_pkg::SRL, isa_pkg::SRLI:   return a >> y[4:0];
      isa_pkg::SRA, isa_pkg::SRAI:   return $signed(a) >>> y[4:0];
      isa_pkg::OR, isa_pkg::ORI:     return a | y;
      isa_pkg::AND, isa_pkg::ANDI:   return a & y;
      default:                       return a + y;
    endcase
  endfunction

  function automatic logic [`EXEC_XLEN-1:0] model_pc(
    input isa_pkg::fu_op_e op, input isa_pkg::fu_func_e fn,
    input logic [`EXEC_XLEN-1:0] a, input logic [`EXEC_XLEN-1:0] b,
    input logic [`EXEC_XLEN-1:0] imm, input logic [`EXEC_XLEN-1:0] pc);
    logic                  taken;
    logic [`EXEC_XLEN-1:0] tgt;
    case (fn)
      isa_pkg::BEQ:  taken = (a == b);
      isa_pkg::BNE:  taken = (a != b);
      isa_pkg::BLT:  taken = ($signed(a) < $signed(b));
      isa_pkg::BGE:  taken = ($signed(a) >= $signed(b));
      isa_pkg::BLTU: taken = (a < b);
      isa_pkg::BGEU: taken = (a >= b);
      default:       taken = 1'b0;
    endcase
    tgt = a + imm;
    case (op)
      isa_pkg::JAL:    return pc + imm;
      isa_pkg::JALR:   return {tgt[`EXEC_XLEN-1:1], 1'b0};
      isa_pkg::BRANCH: return taken ? (pc + imm) : (pc + `EXEC_XLEN'd4);
      default:         return pc + `EXEC_XLEN'd4;
    endcase
  endfunction

  assign accept   = uop_valid_i && !busy_i;
  assign exp_busy = since_acc inside {3'd1, 3'd2, 3'd3};
  assign exp_wb   = (since_acc == 3'd3);

  // operands are read from the shadow registers when the micro-op is accepted
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `EXEC_NREGS; i++) begin
        sregs[i] <= '0;
      end
      spc       <= '0;
      scnt      <= '0;
      exp_res   <= '0;
      exp_pc    <= '0;
      exp_wr    <= 1'b0;
      exp_rd    <= '0;
      since_acc <= 3'd0;
    end else begin
      if (accept) begin
        exp_res   <= model_res(fu_op_i, fu_func_i, sregs[rs1_addr_i], sregs[rs2_addr_i],
                               imm_i, spc);
        exp_pc    <= model_pc(fu_op_i, fu_func_i, sregs[rs1_addr_i], sregs[rs2_addr_i],
                              imm_i, spc);
        exp_wr    <= (fu_op_i != isa_pkg::BRANCH);
        exp_rd    <= rd_addr_i;
        since_acc <= 3'd1;
      end else if (exp_busy) begin
        since_acc <= since_acc + 3'd1;
      end else begin
        since_acc <= 3'd0;
      end
      if (wb_valid_i) begin
        if (exp_wr && (exp_rd != '0)) begin
          sregs[exp_rd] <= exp_res;
        end
        spc  <= exp_pc;
        scnt <= scnt + `EXEC_XLEN'd1;
      end
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////
  reset_state: assert property (@(posedge clk_i) $rose(rst_n_i) |->
      !busy_i && !wb_valid_i && (pc_i == '0) && (retire_cnt_i == '0))
    else begin
      $error("FAIL reset_state expected 0 0 0 0 actual %b %b %h %h",
             $sampled(busy_i), $sampled(wb_valid_i), $sampled(pc_i), $sampled(retire_cnt_i));
      err_cnt++;
    end

  busy_window: assert property (@(posedge clk_i) disable iff (!rst_n_i) busy_i == exp_busy)
    else begin
      $error("FAIL busy_window expected %b actual %b", $sampled(exp_busy), $sampled(busy_i));
      err_cnt++;
    end

  wb_timing: assert property (@(posedge clk_i) disable iff (!rst_n_i) wb_valid_i == exp_wb)
    else begin
      $error("FAIL wb_timing expected %b actual %b", $sampled(exp_wb), $sampled(wb_valid_i));
      err_cnt++;
    end

  wb_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wb_valid_i && exp_wr |-> wb_data_i == exp_res)
    else begin
      $error("FAIL wb_data expected %h actual %h", $sampled(exp_res), $sampled(wb_data_i));
      err_cnt++;
    end

  wb_rd: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wb_valid_i && exp_wr |-> wb_rd_i == exp_rd)
    else begin
      $error("FAIL wb_rd expected %0d actual %0d", $sampled(exp_rd), $sampled(wb_rd_i));
      err_cnt++;
    end

  pc_track: assert property (@(posedge clk_i) disable iff (!rst_n_i) pc_i == spc)
    else begin
      $error("FAIL pc_track expected %h actual %h", $sampled(spc), $sampled(pc_i));
      err_cnt++;
    end

  retire_track: assert property (@(posedge clk_i) disable iff (!rst_n_i) retire_cnt_i == scnt)
    else begin
      $error("FAIL retire_track expected %0d actual %0d", $sampled(scnt),
             $sampled(retire_cnt_i));
      err_cnt++;
    end

endmodule

bind exec_core exec_core_sva u_sva (
  .clk_i(clk_i), .rst_n_i(rst_n_i), .uop_valid_i(uop_valid_i), .fu_op_i(fu_op_i),
  .fu_func_i(fu_func_i), .rs1_addr_i(rs1_addr_i), .rs2_addr_i(rs2_addr_i),
  .rd_addr_i(rd_addr_i), .imm_i(imm_i), .busy_i(busy_o), .wb_valid_i(wb_valid_o),
  .wb_rd_i(wb_rd_o), .wb_data_i(wb_data_o), .pc_i(pc_o), .retire_cnt_i(retire_cnt_o)
);

// File: bench/exec_core_tb.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_core_tb;

  // 94 micro-ops at 4 cycles each plus reset, with margin
  localparam int MAX_CYCLES  = 600;
  localparam int RAND_ROUNDS = 8;

  localparam isa_pkg::fu_func_e ALR_FN [10] = '{
    isa_pkg::ADD, isa_pkg::SUB, isa_pkg::SLL, isa_pkg::SLT, isa_pkg::SLTU,
    isa_pkg::XOR, isa_pkg::SRL, isa_pkg::SRA, isa_pkg::OR, isa_pkg::AND
  };
  localparam isa_pkg::fu_func_e ALI_FN [9] = '{
    isa_pkg::ADDI, isa_pkg::SLLI, isa_pkg::SLTI, isa_pkg::SLTUI, isa_pkg::XORI,
    isa_pkg::SRLI, isa_pkg::SRAI, isa_pkg::ORI, isa_pkg::ANDI
  };
  localparam isa_pkg::fu_func_e BR_FN [6] = '{
    isa_pkg::BEQ, isa_pkg::BNE, isa_pkg::BLT, isa_pkg::BGE, isa_pkg::BLTU, isa_pkg::BGEU
  };

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  uop_valid;
  isa_pkg::fu_op_e       fu_op;
  isa_pkg::fu_func_e     fu_func;
  logic [`EXEC_RA_W-1:0] rs1_addr;
  logic [`EXEC_RA_W-1:0] rs2_addr;
  logic [`EXEC_RA_W-1:0] rd_addr;
  logic [`EXEC_XLEN-1:0] imm;
  logic                  busy;
  logic                  wb_valid;
  logic [`EXEC_RA_W-1:0] wb_rd;
  logic [`EXEC_XLEN-1:0] wb_data;
  logic [`EXEC_XLEN-1:0] pc;
  logic [`EXEC_XLEN-1:0] retire_cnt;
  logic [31:0]           lfsr_state = 32'd67;
  int                    cycles = 0;

  exec_core dut0 (
    .clk_i(clk), .rst_n_i(rst_n), .uop_valid_i(uop_valid), .fu_op_i(fu_op),
    .fu_func_i(fu_func), .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr), .rd_addr_i(rd_addr),
    .imm_i(imm), .busy_o(busy), .wb_valid_o(wb_valid), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
    .pc_o(pc), .retire_cnt_o(retire_cnt)
  );

  always #5 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      fail_run("timeout: the micro-op sequence did not finish within the cycle limit");
    end
  end

  // the bound checker counts its failing assertions
  always @(negedge clk) begin
    if (dut0.u_sva.err_cnt != 0) begin
      fail_run("a bound assertion failed");
    end
  end

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // called 1 ns after an edge with busy low, returns the same way
  task automatic issue(input isa_pkg::fu_op_e op, input isa_pkg::fu_func_e fn,
                       input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd,
                       input logic [31:0] imm_v);
    fu_op     = op;
    fu_func   = fn;
    rs1_addr  = rs1;
    rs2_addr  = rs2;
    rd_addr   = rd;
    imm       = imm_v;
    uop_valid = 1'b1;
    @(posedge clk);
    #1;
    uop_valid = 1'b0;
    while (busy) begin
      @(posedge clk);
      #1;
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] rc;
    int unsigned sel;
    rst_n     = 1'b0;
    uop_valid = 1'b0;
    fu_op     = isa_pkg::ALR;
    fu_func   = isa_pkg::NONE;
    rs1_addr  = '0;
    rs2_addr  = '0;
    rd_addr   = '0;
    imm       = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // x1 is negative, x2 and x4 hold 5, x3 holds -3
    issue(isa_pkg::LUI, isa_pkg::NONE, 5'd0, 5'd0, 5'd1, 32'h8000_0000);
    issue(isa_pkg::ALI, isa_pkg::ADDI, 5'd0, 5'd0, 5'd2, 32'd5);
    issue(isa_pkg::ALI, isa_pkg::ADDI, 5'd0, 5'd0, 5'd3, 32'hFFFF_FFFD);
    issue(isa_pkg::ALI, isa_pkg::ADDI, 5'd0, 5'd0, 5'd4, 32'd5);
    for (int i = 0; i < 10; i++) begin
      issue(isa_pkg::ALR, ALR_FN[i], 5'd3, 5'd2, 5'd5, 32'd0);
    end
    for (int i = 0; i < 9; i++) begin
      issue(isa_pkg::ALI, ALI_FN[i], 5'd1, 5'd0, 5'd6, 32'hFFFF_FFF3);
    end
    issue(isa_pkg::AUIPC, isa_pkg::NONE, 5'd0, 5'd0, 5'd7, 32'h0001_2000);

    // equal, signed less-than and sign-crossing pairs; x8 must stay zero
    for (int i = 0; i < 6; i++) begin
      issue(isa_pkg::BRANCH, BR_FN[i], 5'd2, 5'd4, 5'd8, 32'd16);
      issue(isa_pkg::BRANCH, BR_FN[i], 5'd3, 5'd2, 5'd8, 32'hFFFF_FFF0);
      issue(isa_pkg::BRANCH, BR_FN[i], 5'd2, 5'd1, 5'd8, 32'd24);
    end
    issue(isa_pkg::JAL, isa_pkg::NONE, 5'd0, 5'd0, 5'd10, 32'd32);
    // the jalr target 5+8 is odd, so bit 0 has to be cleared
    issue(isa_pkg::JALR, isa_pkg::NONE, 5'd2, 5'd0, 5'd11, 32'd8);
    issue(isa_pkg::ALI, isa_pkg::ADDI, 5'd0, 5'd0, 5'd0, 32'd123);
    issue(isa_pkg::ALR, isa_pkg::ADD, 5'd0, 5'd8, 5'd9, 32'd0);

    for (int k = 0; k < RAND_ROUNDS; k++) begin
      take_bits(32, ra);
      take_bits(12, rb);
      issue(isa_pkg::LUI, isa_pkg::NONE, 5'd0, 5'd0, 5'd12, {ra[31:12], 12'h000});
      issue(isa_pkg::ALI, isa_pkg::ADDI, 5'd12, 5'd0, 5'd12, {{20{rb[11]}}, rb[11:0]});
      take_bits(32, ra);
      take_bits(12, rb);
      issue(isa_pkg::LUI, isa_pkg::NONE, 5'd0, 5'd0, 5'd13, {ra[31:12], 12'h000});
      issue(isa_pkg::ALI, isa_pkg::ADDI, 5'd13, 5'd0, 5'd13, {{20{rb[11]}}, rb[11:0]});
      take_bits(4, ra);
      take_bits(5, rb);
      sel = ra % 10;
      issue(isa_pkg::ALR, ALR_FN[sel], 5'd12, 5'd13, rb[4:0], 32'd0);
      take_bits(4, ra);
      take_bits(5, rb);
      take_bits(12, rc);
      sel = ra % 9;
      issue(isa_pkg::ALI, ALI_FN[sel], 5'd12, 5'd0, rb[4:0], {{20{rc[11]}}, rc[11:0]});
    end

    repeat (2) @(posedge clk);
    #1;
    if (dut0.u_sva.err_cnt == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      fail_run("bound assertions reported failures");
    end
  end

endmodule

// File: files.f
+incdir+include
src/isa_pkg.sv
src/ctrl_pkg.sv
src/alu.sv
src/regfile.sv
src/uop_latch.sv
src/pc_counter.sv
src/exec_ctrl.sv
src/exec_core.sv
bench/exec_core_sva.sv
bench/exec_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= exec_core_tb
FILELIST  ?= files.f
FLAGS     ?= --timing --assert
SIM_FLAGS ?= -Wno-fatal
OBJ_DIR   ?= obj_dir
# bound assertions keep counting so the testbench itself ends a failing run
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)
